// ==== all.f ====
+incdir+include
src/decode_pkg.sv
src/inst_decoder.sv
src/imm_gen.sv
src/operand_lane.sv
src/decode_issue.sv
src/id_stage_top.sv
tb/id_stage_asserts.sv
tb/id_stage_tb.sv

// ==== tb/id_stage_tb.sv ====
// directed tests of the decode stage; gpr is random from seed 75, issue_ready tied high, unused
`timescale 1ns/10ps
`include "decode_params.svh"

module id_stage_tb import decode_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    localparam int CLK_NS      = 40;
    localparam int WAIT_LIMIT  = 20;                            // cycles before a wait gives up
    localparam int WATCHDOG_NS = (NUM_TESTS * 40 + 100) * CLK_NS;

    logic                 clk;
    logic                 rst;
    logic                 fetch_valid;
    fetch_pkt_t           fetch;
    logic                 fetch_ready;
    gpr_file_t            gpr;
    logic [`NUM_REGS-1:0] gpr_busy;
    logic                 issue_valid;
    issue_pkt_t           issue;
    logic                 issue_ready;
    int                   errors;
    int                   checks;
    int                   tests_run;

    id_stage_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .gpr         (gpr),
        .gpr_busy    (gpr_busy),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    task automatic check_op(input string name, input rv_op_e got, input rv_op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h (%s) expected %h (%s)",
                     name, got, got.name(), exp, exp.name());
        end
    endtask

    task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // instruction builders straight from the base encoding tables
    function automatic logic [31:0] enc_r(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [6:0] f7, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    task automatic test_done(input string name, input int errs_before);
        tests_run++;
        $display("test %-9s finished with %0d errors", name, errors - errs_before);
    endtask

    // waits for fetch_ready, presents one packet, returns with it on issue
    task automatic issue_one(input logic [63:0] pc, input logic [31:0] inst);
        int n;
        n = 0;
        @(negedge clk);
        while (!fetch_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!fetch_ready) begin
            errors++;
            $display("fetch_ready stayed low, packet at pc %h was never accepted", pc);
        end
        fetch_valid = 1'b1;
        fetch.pc    = pc;
        fetch.inst  = inst;
        @(negedge clk);                                         // taken at the rising edge
        fetch_valid = 1'b0;
    endtask

    task automatic decode_case(input string name, input logic [31:0] inst, input rv_op_e op,
                               input logic [4:0] rd, input logic wen, input logic has_imm,
                               input logic [63:0] imm);
        issue_one(64'h8000_0000, inst);
        check_bit({name, " issue_valid"}, issue_valid, 1'b1);
        check_word({name, " inst"}, issue.inst, inst);
        check_op({name, " op"}, issue.op, op);
        check_bit({name, " wen"}, issue.wen, wen);
        if (wen)
            check_reg({name, " rd"}, issue.rd, rd);
        if (has_imm)                                            // R-type carries no immediate
            check_word({name, " imm"}, issue.imm, imm);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_bit("reset issue_valid", issue_valid, 1'b0);
        check_bit("reset fetch_ready", fetch_ready, 1'b1);
        test_done("reset", e0);
    endtask

    task automatic test_decode();
        int e0;
        e0 = errors;
        decode_case("lui", enc_u(`OPC_LUI, 5'd5, 20'hfffff), OP_LUI, 5'd5, 1, 1,
                    64'hffff_ffff_ffff_f000);
        decode_case("auipc", enc_u(`OPC_AUIPC, 5'd6, 20'h12345), OP_AUIPC, 5'd6, 1, 1,
                    64'h0000_0000_1234_5000);
        decode_case("jal", enc_j(5'd1, 21'h1a5a56), OP_JAL, 5'd1, 1, 1,
                    64'hffff_ffff_fffa_5a56);                   // negative, scrambled
        decode_case("jalr", enc_i(`OPC_JALR, 3'b000, 5'd1, 5'd2, 12'h7ff), OP_JALR, 5'd1, 1, 1,
                    64'h0000_0000_0000_07ff);
        decode_case("beq", enc_b(3'b000, 5'd3, 5'd4, 13'h1ff4), OP_BEQ, 5'd0, 0, 1,
                    64'hffff_ffff_ffff_fff4);
        decode_case("bgeu", enc_b(3'b111, 5'd5, 5'd6, 13'h0aa6), OP_BGEU, 5'd0, 0, 1,
                    64'h0000_0000_0000_0aa6);                   // imm bit 11 set
        decode_case("ld", enc_i(`OPC_LOAD, 3'b011, 5'd7, 5'd8, 12'hff8), OP_LD, 5'd7, 1, 1,
                    64'hffff_ffff_ffff_fff8);
        decode_case("sd", enc_s(3'b011, 5'd10, 5'd9, 12'h804), OP_SD, 5'd0, 0, 1,
                    64'hffff_ffff_ffff_f804);
        decode_case("addi", enc_i(`OPC_OPIMM, 3'b000, 5'd11, 5'd12, 12'h123), OP_ADDI,
                    5'd11, 1, 1, 64'h0000_0000_0000_0123);
        decode_case("srai", enc_i(`OPC_OPIMM, 3'b101, 5'd13, 5'd14, {`F6_ALT, 6'd33}),
                    OP_SRAI, 5'd13, 1, 1, 64'h0000_0000_0000_0421);
        decode_case("sub", enc_r(`OPC_OP, 3'b000, `F7_ALT, 5'd18, 5'd19, 5'd20), OP_SUB,
                    5'd18, 1, 0, 64'h0);
        decode_case("addiw", enc_i(`OPC_OPIMM32, 3'b000, 5'd21, 5'd22, 12'h800), OP_ADDIW,
                    5'd21, 1, 1, 64'hffff_ffff_ffff_f800);
        decode_case("sraw", enc_r(`OPC_OP32, 3'b101, `F7_ALT, 5'd25, 5'd26, 5'd27), OP_SRAW,
                    5'd25, 1, 0, 64'h0);
        test_done("decode", e0);
    endtask

    task automatic test_operands();
        int         e0;
        logic [4:0] rs1;
        logic [4:0] rs2;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            rs1 = 5'($urandom);
            rs2 = 5'($urandom);
            issue_one(64'h2000 + 4 * i, enc_r(`OPC_OP, 3'b110, `F7_BASE, 5'd1, rs1, rs2));
            check_word("src_a", issue.src_a, gpr[rs1]);
            check_word("src_b", issue.src_b, gpr[rs2]);
        end
        test_done("operands", e0);
    endtask

    // busy source holds the packet until the bit drops
    task automatic stall_case(input string name, input logic [31:0] inst, input int busy_idx);
        int n;
        n = 0;
        @(negedge clk);                                         // previous slot drains
        gpr_busy[busy_idx] = 1'b1;
        issue_one(64'h3000 + busy_idx, inst);
        check_bit({name, " fetch_ready"}, fetch_ready, 1'b0);
        check_bit({name, " issue_valid"}, issue_valid, 1'b0);
        check_bit({name, " issue zero"}, issue == '0, 1'b1);
        fetch_valid = 1'b1;                                     // decoy the register must ignore
        fetch.pc    = 64'h3f00;
        fetch.inst  = enc_i(`OPC_OPIMM, 3'b000, 5'd0, 5'd0, 12'h0);
        repeat (2) begin
            @(negedge clk);
            check_bit({name, " held fetch_ready"}, fetch_ready, 1'b0);
        end
        fetch_valid = 1'b0;
        gpr_busy    = '0;
        #(CLK_NS / 4);                                          // lanes and issue are combinational
        while (!issue_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            #(CLK_NS / 4);
            n++;
        end
        if (!issue_valid) begin
            errors++;
            $display("%s: instruction never issued after busy cleared", name);
        end
        check_word({name, " pc"}, issue.pc, 64'h3000 + busy_idx);
        check_word({name, " inst"}, issue.inst, inst);
    endtask

    task automatic free_case(input string name, input logic [31:0] inst,
                             input logic [31:0] busy, input rv_op_e op, input logic wen);
        @(negedge clk);
        gpr_busy = busy;
        issue_one(64'h4000, inst);
        check_bit({name, " fetch_ready"}, fetch_ready, 1'b1);
        check_bit({name, " issue_valid"}, issue_valid, 1'b1);
        check_op({name, " op"}, issue.op, op);
        check_bit({name, " wen"}, issue.wen, wen);
        gpr_busy = '0;
    endtask

    task automatic test_stall();
        int e0;
        e0 = errors;
        stall_case("rs1 busy", enc_r(`OPC_OP, 3'b000, `F7_BASE, 5'd1, 5'd3, 5'd4), 3);
        stall_case("rs2 busy", enc_s(3'b011, 5'd6, 5'd7, 12'h010), 7);     // store data
        free_case("addi rs2 field", enc_i(`OPC_OPIMM, 3'b000, 5'd1, 5'd2, 12'h005),
                  32'h1 << 5, OP_ADDI, 1'b1);
        free_case("lui all busy", enc_u(`OPC_LUI, 5'd9, 20'h00abc), '1, OP_LUI, 1'b1);
        test_done("stall", e0);
    endtask

    task automatic test_illegal();
        int e0;
        e0 = errors;
        free_case("mul", enc_r(`OPC_OP, 3'b000, 7'b0000001, 5'd1, 5'd2, 5'd3), '1,
                  OP_ILLEGAL, 1'b0);
        free_case("csrrw", enc_i(7'b1110011, 3'b001, 5'd1, 5'd2, 12'h300), '1,
                  OP_ILLEGAL, 1'b0);
        free_case("ecall", 32'h0000_0073, '1, OP_ILLEGAL, 1'b0);
        test_done("illegal", e0);
    endtask

    // one addi per cycle, each must appear one edge after acceptance
    task automatic test_stream();
        int          e0;
        logic [63:0] pc_q[$];
        logic [31:0] inst_q[$];
        e0 = errors;
        @(negedge clk);
        for (int i = 0; i <= 8; i++) begin
            if (i > 0) begin
                check_bit("stream issue_valid", issue_valid, 1'b1);
                check_word("stream pc", issue.pc, pc_q.pop_front());
                check_word("stream inst", issue.inst, inst_q.pop_front());
            end
            check_bit("stream fetch_ready", fetch_ready, 1'b1);
            if (i < 8) begin
                pc_q.push_back(64'h5000 + 4 * i);
                inst_q.push_back(enc_i(`OPC_OPIMM, 3'b000, 5'(i + 1), 5'(i), 12'(3 * i)));
                fetch_valid = 1'b1;
                fetch.pc    = pc_q[$];
                fetch.inst  = inst_q[$];
            end else begin
                fetch_valid = 1'b0;
            end
            @(negedge clk);
        end
        test_done("stream", e0);
    endtask

    initial begin
        void'($urandom(75));
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        gpr_busy    = '0;
        issue_ready = 1'b1;
        for (int r = 0; r < `NUM_REGS; r++)
            gpr[r] = {$urandom, $urandom};                      // random file contents
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_decode();
        test_operands();
        test_stall();
        test_illegal();
        test_stream();
        errors = errors + dut0.u_asserts.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== tb/id_stage_asserts.sv ====
// bound to id_stage_top; all properties sampled on the rising edge and off while rst is high
`timescale 1ns/10ps
`include "decode_params.svh"

module id_stage_asserts import decode_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 fetch_ready,
    input logic                 issue_valid,
    input issue_pkt_t           issue,
    input logic [`ILEN-1:0]     held_inst,
    input logic [`NUM_REGS-1:0] gpr_busy
);

    int fail_count = 0;                                         // read by the testbench summary

    // a stalled stage hands nothing to execute, and the stall comes from a busy rs1 or rs2
    a_no_issue_on_stall: assert property (@(posedge clk) disable iff (rst)
        !fetch_ready |-> !issue_valid
            && (gpr_busy[held_inst[19:15]] || gpr_busy[held_inst[24:20]]))
        else begin
            fail_count++;
            $error("issue_valid high or no busy source while fetch_ready low");
        end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        !fetch_ready |=> $stable(held_inst))                    // register must not reload
        else begin
            fail_count++;
            $error("held instruction changed across a stalled cycle");
        end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue.op == OP_ILLEGAL) |-> !issue.wen)
        else begin
            fail_count++;
            $error("illegal operation issued with wen set");
        end

endmodule

bind id_stage_top id_stage_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .fetch_ready (fetch_ready),
    .issue_valid (issue_valid),
    .issue       (issue),
    .held_inst   (held_inst),
    .gpr_busy    (gpr_busy)
);

// ==== src/id_stage_top.sv ====
// decode stage of an RV64I pipeline; one cycle from fetch to issue, issue_ready unused
`timescale 1ns/10ps
`include "decode_params.svh"

module id_stage_top import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_valid,
    input  fetch_pkt_t            fetch,
    output logic                  fetch_ready,
    input  gpr_file_t             gpr,
    input  logic [`NUM_REGS-1:0]  gpr_busy,
    output logic                  issue_valid,
    output issue_pkt_t            issue,
    input  logic                  issue_ready     // downstream stalls arrive via gpr_busy
);

    logic [`ILEN-1:0]               held_inst;
    dec_ctrl_t                      ctrl;
    imm_fmt_e                       fmt;
    src_req_t [`NUM_SRC-1:0]        src_req;
    logic [`XLEN-1:0]               imm;
    logic [`NUM_SRC-1:0][`XLEN-1:0] operands;
    logic [`NUM_SRC-1:0]            conflicts;

    decode_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .held_inst   (held_inst),
        .ctrl        (ctrl),
        .imm         (imm),
        .operands    (operands),
        .conflicts   (conflicts),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    inst_decoder u_dec (
        .inst    (held_inst),
        .ctrl    (ctrl),
        .fmt     (fmt),
        .src_req (src_req)
    );

    imm_gen u_imm (
        .inst (held_inst),
        .fmt  (fmt),
        .imm  (imm)
    );

    // lane 0 serves rs1, lane 1 rs2
    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_lane
        operand_lane u_lane (
            .req      (src_req[i]),
            .gpr      (gpr),
            .gpr_busy (gpr_busy),
            .operand  (operands[i]),
            .conflict (conflicts[i])
        );
    end

endmodule

// ==== src/decode_issue.sv ====
// single ID register; stalls only on scoreboard conflicts, issue_ready is not looked at here
`timescale 1ns/10ps
`include "decode_params.svh"

module decode_issue import decode_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             fetch_valid,
    input  fetch_pkt_t                       fetch,
    output logic                             fetch_ready,
    output logic [`ILEN-1:0]                 held_inst,
    input  dec_ctrl_t                        ctrl,
    input  logic [`XLEN-1:0]                 imm,
    input  logic [`NUM_SRC-1:0][`XLEN-1:0]   operands,
    input  logic [`NUM_SRC-1:0]              conflicts,
    output logic                             issue_valid,
    output issue_pkt_t                       issue
);

    logic       held_valid;
    fetch_pkt_t held;
    logic       stall;

    assign stall       = |conflicts;        // any used source still busy
    assign fetch_ready = ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (!stall) begin
            held_valid <= fetch_valid;      // bubble when fetch is idle
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            held <= fetch;                  // hold pc/inst across the stall
        end
    end

    // empty slot decodes as the zero word, illegal with no sources
    assign held_inst = held_valid ? held.inst : '0;

    always_comb begin
        issue       = '0;                   // zeros while stalled
        issue_valid = 1'b0;
        if (!stall) begin
            issue_valid = held_valid;
            issue.pc    = held.pc;
            issue.inst  = held_inst;
            issue.op    = ctrl.op;
            issue.rd    = ctrl.rd;
            issue.wen   = ctrl.wen;
            issue.src_a = operands[0];      // rs1 lane
            issue.src_b = operands[1];      // rs2 lane
            issue.imm   = imm;
        end
    end

endmodule

// ==== src/operand_lane.sv ====
// one source port; no bypass, a busy register stalls until its bit drops, x0 read as given
`timescale 1ns/10ps
`include "decode_params.svh"

module operand_lane import decode_pkg::*; (
    input  src_req_t              req,
    input  gpr_file_t             gpr,
    input  logic [`NUM_REGS-1:0]  gpr_busy,
    output logic [`XLEN-1:0]      operand,
    output logic                  conflict
);

    logic busy_bit;

    assign operand  = gpr[req.idx];         // plain read, even when unused
    assign busy_bit = gpr_busy[req.idx];    // scoreboard entry for this source

    // only a source the instruction reads can hold it back
    assign conflict = req.used & busy_bit;

endmodule

// ==== src/imm_gen.sv ====
// all immediates sign extended from inst[31]; R-type words get the I value, unused downstream
`timescale 1ns/10ps
`include "decode_params.svh"

module imm_gen import decode_pkg::*; (
    input  logic [`ILEN-1:0] inst,
    input  imm_fmt_e         fmt,
    output logic [`XLEN-1:0] imm
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};   // split field
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7],
                    inst[30:25], inst[11:8], 1'b0};                     // halfword offset
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12],
                    inst[20], inst[30:21], 1'b0};                       // jal scramble

    always_comb begin
        case (fmt)
            FMT_S:   imm = imm_s;
            FMT_B:   imm = imm_b;
            FMT_U:   imm = imm_u;
            FMT_J:   imm = imm_j;
            default: imm = imm_i;           // I and R-type
        endcase
    end

endmodule

// ==== src/inst_decoder.sv ====
// RV64I only; M, CSR, fence and system words come out illegal with no rd write and no sources
`timescale 1ns/10ps
`include "decode_params.svh"

module inst_decoder import decode_pkg::*; (
    input  logic [`ILEN-1:0]        inst,
    output dec_ctrl_t               ctrl,
    output imm_fmt_e                fmt,
    output src_req_t [`NUM_SRC-1:0] src_req
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_op_e     op;
    logic       wen;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op      = OP_ILLEGAL;
        fmt     = FMT_I;
        wen     = 1'b1;                     // most groups write rd
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                op      = OP_LUI;
                fmt     = FMT_U;
                use_rs1 = 1'b0;
            end
            `OPC_AUIPC: begin
                op      = OP_AUIPC;
                fmt     = FMT_U;
                use_rs1 = 1'b0;
            end
            `OPC_JAL: begin
                op      = OP_JAL;
                fmt     = FMT_J;
                use_rs1 = 1'b0;
            end
            `OPC_JALR: if (funct3 == 3'b000) op = OP_JALR;
            `OPC_BRANCH: begin
                fmt     = FMT_B;            // B imm here, not I
                wen     = 1'b0;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            `OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b011:  op = OP_LD;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    3'b110:  op = OP_LWU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            `OPC_STORE: begin
                fmt     = FMT_S;
                wen     = 1'b0;
                use_rs2 = 1'b1;             // store data
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    3'b011:  op = OP_SD;
                    default: op = OP_ILLEGAL;
                endcase
            end
            `OPC_OPIMM: begin
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    3'b001:  if (inst[31:26] == `F6_BASE) op = OP_SLLI;   // 6-bit shamt
                    default: begin
                        if (inst[31:26] == `F6_BASE)     op = OP_SRLI;
                        else if (inst[31:26] == `F6_ALT) op = OP_SRAI;
                    end
                endcase
            end
            `OPC_OP: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {`F7_BASE, 3'b000}: op = OP_ADD;
                    {`F7_ALT,  3'b000}: op = OP_SUB;
                    {`F7_BASE, 3'b001}: op = OP_SLL;
                    {`F7_BASE, 3'b010}: op = OP_SLT;
                    {`F7_BASE, 3'b011}: op = OP_SLTU;
                    {`F7_BASE, 3'b100}: op = OP_XOR;
                    {`F7_BASE, 3'b101}: op = OP_SRL;
                    {`F7_ALT,  3'b101}: op = OP_SRA;
                    {`F7_BASE, 3'b110}: op = OP_OR;
                    {`F7_BASE, 3'b111}: op = OP_AND;
                    default:            op = OP_ILLEGAL;   // mul/div land here
                endcase
            end
            `OPC_OPIMM32: begin
                case ({funct7, funct3})
                    {`F7_BASE, 3'b001}: op = OP_SLLIW;
                    {`F7_BASE, 3'b101}: op = OP_SRLIW;
                    {`F7_ALT,  3'b101}: op = OP_SRAIW;
                    default:            if (funct3 == 3'b000) op = OP_ADDIW;
                endcase
            end
            `OPC_OP32: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {`F7_BASE, 3'b000}: op = OP_ADDW;
                    {`F7_ALT,  3'b000}: op = OP_SUBW;
                    {`F7_BASE, 3'b001}: op = OP_SLLW;
                    {`F7_BASE, 3'b101}: op = OP_SRLW;
                    {`F7_ALT,  3'b101}: op = OP_SRAW;
                    default:            op = OP_ILLEGAL;
                endcase
            end
            default: op = OP_ILLEGAL;       // csr, ecall, fence, zero word
        endcase
        if (op == OP_ILLEGAL) begin         // never writes, never stalls
            wen     = 1'b0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    always_comb begin
        src_req[0].idx  = inst[19:15];
        src_req[0].used = use_rs1;
        src_req[1].idx  = inst[24:20];
        src_req[1].used = use_rs2;
        ctrl.op         = op;
        ctrl.fmt        = fmt;
        ctrl.rd         = inst[11:7];
        ctrl.wen        = wen;
        ctrl.src        = src_req;
    end

endmodule

// ==== src/decode_pkg.sv ====
// operation and format types for the decode stage; no M, CSR or system instructions
`include "decode_params.svh"

package decode_pkg;

    // one code per kept RV64I instruction, illegal sits at zero
    typedef enum logic [5:0] {
        OP_ILLEGAL = 6'd0,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW
    } rv_op_e;

    typedef enum logic [2:0] {
        FMT_I = 3'd0,                       // also used for R-type, imm ignored
        FMT_S = 3'd1,
        FMT_B = 3'd2,
        FMT_U = 3'd3,
        FMT_J = 3'd4
    } imm_fmt_e;

    // what fetch hands over, valid travels beside it
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`ILEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] idx;        // rs1 or rs2 field
        logic                   used;       // instruction really reads it
    } src_req_t;

    typedef struct packed {
        rv_op_e                 op;
        imm_fmt_e               fmt;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   wen;        // writes rd
        src_req_t [`NUM_SRC-1:0] src;       // [0] rs1, [1] rs2
    } dec_ctrl_t;

    // whole register file as one packed bus
    typedef logic [`NUM_REGS-1:0][`XLEN-1:0] gpr_file_t;

    // toward execute, all zero while stalled
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`ILEN-1:0]       inst;
        rv_op_e                 op;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   wen;
        logic [`XLEN-1:0]       src_a;      // gpr[rs1]
        logic [`XLEN-1:0]       src_b;      // gpr[rs2]
        logic [`XLEN-1:0]       imm;        // sign extended, per format
    } issue_pkt_t;

endpackage

// ==== include/decode_params.svh ====
// RV64I base encodings only; widths assume a 32-entry integer register file
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define XLEN        64              // data and pc width
`define ILEN        32              // instruction width
`define NUM_REGS    32              // integer registers
`define REG_ADDR_W  5               // register index width
`define NUM_SRC     2               // rs1 and rs2 lanes

`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OPIMM   7'b0010011
`define OPC_OP      7'b0110011
`define OPC_OPIMM32 7'b0011011
`define OPC_OP32    7'b0111011

`define F7_BASE     7'b0000000      // add, srl and friends
`define F7_ALT      7'b0100000      // sub, sra
`define F6_BASE     6'b000000       // rv64 immediate shifts, upper six bits
`define F6_ALT      6'b010000       // srai

`endif
